//--- rv_pkg.sv
package rv_pkg;

	// ####################################################################
	// operation and operand encodings
	// ####################################################################

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		OPD_ZERO,
		OPD_RS1,
		OPD_RS2,
		OPD_PC,
		OPD_IMM
	} operand_sel_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} branch_cond_t;

	// ####################################################################
	// stage records
	// ####################################################################

	typedef struct packed {
		logic tag;
		logic [31:0] pc;
		logic [31:0] instruction;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
	} fetch_data_t;

	typedef struct packed {
		logic tag;
		logic [31:0] pc;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [31:0] imm;
		alu_op_t alu_operation;
		operand_sel_t alu_operand1;
		operand_sel_t alu_operand2;
		branch_cond_t branch_cond;
		logic jump;
		logic writes_rd;
		logic [1:0] have_rs; // bit 0 reads rs1, bit 1 reads rs2
	} decode_data_t;

	typedef struct packed {
		logic [4:0] rd;
		logic [31:0] value;
	} wb_data_t;

	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

//--- rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_inst_valid,
	input logic [31:0] i_inst,
	output fetch_data_t o_data
);

	logic [31:0] pc;
	fetch_data_t data;

	assign o_data = data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= RESET_PC;
			data <= '0;
		end
		else if (i_inst_valid) begin
			data.tag <= ~data.tag; // a flipped tag tells decode a new word is here
			data.pc <= pc;
			data.instruction <= i_inst;
			data.rs1 <= i_inst[19:15];
			data.rs2 <= i_inst[24:20];
			data.rd <= i_inst[11:7];

			// no redirects, the counter only ever steps by one word
			pc <= pc + 32'd4;
		end
	end

endmodule

//--- rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input fetch_data_t i_data,
	output decode_data_t o_data,
	output logic o_fault
);

	logic in_tag; // last fetch tag taken in, kept apart from the outgoing tag
	decode_data_t data;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	logic supported;
	logic [31:0] imm;
	alu_op_t alu_operation;
	operand_sel_t operand1;
	operand_sel_t operand2;
	branch_cond_t cond;
	logic jump;
	logic writes_rd;
	logic [1:0] uses_rs;

	assign o_data = data;

	assign opcode = i_data.instruction[6:0];
	assign funct3 = i_data.instruction[14:12];
	assign funct7 = i_data.instruction[31:25];

	assign imm_i = {{21{i_data.instruction[31]}}, i_data.instruction[30:20]};
	assign imm_b = {{20{i_data.instruction[31]}}, i_data.instruction[7],
		i_data.instruction[30:25], i_data.instruction[11:8], 1'b0};
	assign imm_u = {i_data.instruction[31:12], 12'h000};
	assign imm_j = {{12{i_data.instruction[31]}}, i_data.instruction[19:12],
		i_data.instruction[20], i_data.instruction[30:21], 1'b0};

	function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return alt ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// ####################################################################
	// classification
	// ####################################################################

	always_comb begin
		supported = 1'b0;
		imm = 32'h0;
		alu_operation = ALU_ADD;
		operand1 = OPD_RS1;
		operand2 = OPD_IMM;
		cond = BR_NONE;
		jump = 1'b0;
		writes_rd = 1'b0;
		uses_rs = 2'b00;
		case (opcode)
			OPC_OP_IMM: begin
				supported = (funct3 == 3'b001) ? (funct7 == 7'h00) :
					(funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;
				imm = imm_i; // shifts only use the low five bits
				alu_operation = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
				writes_rd = 1'b1;
				uses_rs = 2'b01;
			end
			OPC_OP: begin
				supported = (funct7 == 7'h00) ||
					(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
				alu_operation = alu_from_funct(funct3, funct7[5]);
				operand2 = OPD_RS2;
				writes_rd = 1'b1;
				uses_rs = 2'b11;
			end
			OPC_LUI: begin
				supported = 1'b1;
				imm = imm_u;
				alu_operation = ALU_PASS_B;
				operand1 = OPD_ZERO;
				writes_rd = 1'b1;
			end
			OPC_AUIPC: begin
				supported = 1'b1;
				imm = imm_u;
				operand1 = OPD_PC;
				writes_rd = 1'b1;
			end
			OPC_JAL: begin
				supported = 1'b1;
				imm = imm_j;
				operand1 = OPD_PC; // the ALU forms the target, execute forms the link
				jump = 1'b1;
				writes_rd = 1'b1;
			end
			OPC_JALR: begin
				supported = (funct3 == 3'b000);
				imm = imm_i;
				jump = 1'b1;
				writes_rd = 1'b1;
				uses_rs = 2'b01;
			end
			OPC_BRANCH: begin
				supported = (funct3 != 3'b010 && funct3 != 3'b011);
				imm = imm_b;
				operand1 = OPD_PC;
				uses_rs = 2'b11; // both registers go to the comparator
				case (funct3)
					3'b000: cond = BR_EQ;
					3'b001: cond = BR_NE;
					3'b100: cond = BR_LT;
					3'b101: cond = BR_GE;
					3'b110: cond = BR_LTU;
					default: cond = BR_GEU;
				endcase
			end
			default: supported = 1'b0;
		endcase
	end

	// ####################################################################
	// decoded record
	// ####################################################################

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			in_tag <= 1'b0;
			data <= '0;
			o_fault <= 1'b0;
		end
		else if (i_data.tag != in_tag) begin
			in_tag <= i_data.tag;
			data.pc <= i_data.pc;
			data.rs1 <= i_data.rs1;
			data.rs2 <= i_data.rs2;
			data.rd <= i_data.rd;
			data.imm <= imm;
			data.alu_operation <= alu_operation;
			data.alu_operand1 <= operand1;
			data.alu_operand2 <= operand2;
			data.branch_cond <= cond;
			data.jump <= jump;
			data.writes_rd <= writes_rd;
			data.have_rs <= uses_rs;
			if (supported)
				data.tag <= ~data.tag;
			else
				o_fault <= 1'b1; // sticky, only reset clears it
		end
	end

endmodule

//--- rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic [4:0] i_rs1,
	input logic [4:0] i_rs2,
	output logic [31:0] o_rs1_value,
	output logic [31:0] o_rs2_value,
	input logic i_we,
	input wb_data_t i_wb
);

	logic [31:0] regs [0:31];

	// a write still on its way in is returned to the reader in the same cycle
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'h0;
		if (i_we && i_wb.rd == addr)
			return i_wb.value;
		return regs[addr];
	endfunction

	assign o_rs1_value = read_port(i_rs1);
	assign o_rs2_value = read_port(i_rs2);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end
		else if (i_we && i_wb.rd != 5'd0) begin
			regs[i_wb.rd] <= i_wb.value;
		end
	end

endmodule

//--- rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input decode_data_t i_data,
	output logic [4:0] o_rs1,
	output logic [4:0] o_rs2,
	input logic [31:0] i_rs1_value,
	input logic [31:0] i_rs2_value,
	output logic o_wb_valid,
	output wb_data_t o_wb,
	output logic o_br_valid,
	output logic o_br_taken,
	output logic [31:0] o_br_target
);

	logic tag;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] result;
	logic cond_true;

	// unused read ports point at x0
	assign o_rs1 = i_data.have_rs[0] ? i_data.rs1 : 5'd0;
	assign o_rs2 = i_data.have_rs[1] ? i_data.rs2 : 5'd0;

	function automatic logic [31:0] select_operand(input operand_sel_t sel);
		case (sel)
			OPD_RS1: return i_rs1_value;
			OPD_RS2: return i_rs2_value;
			OPD_PC: return i_data.pc;
			OPD_IMM: return i_data.imm;
			default: return 32'h0;
		endcase
	endfunction

	assign op_a = select_operand(i_data.alu_operand1);
	assign op_b = select_operand(i_data.alu_operand2);

	always_comb begin
		case (i_data.alu_operation)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR: result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_SLL: result = op_a << op_b[4:0];
			ALU_SRL: result = op_a >> op_b[4:0];
			ALU_SRA: result = $signed(op_a) >>> op_b[4:0];
			ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: result = {31'b0, op_a < op_b};
			ALU_PASS_B: result = op_b;
			default: result = op_a + op_b;
		endcase
	end

	always_comb begin
		case (i_data.branch_cond)
			BR_EQ: cond_true = (i_rs1_value == i_rs2_value);
			BR_NE: cond_true = (i_rs1_value != i_rs2_value);
			BR_LT: cond_true = ($signed(i_rs1_value) < $signed(i_rs2_value));
			BR_GE: cond_true = ($signed(i_rs1_value) >= $signed(i_rs2_value));
			BR_LTU: cond_true = (i_rs1_value < i_rs2_value);
			BR_GEU: cond_true = (i_rs1_value >= i_rs2_value);
			default: cond_true = 1'b0;
		endcase
	end

	// ####################################################################
	// writeback and branch report
	// ####################################################################

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			tag <= 1'b0;
			o_wb_valid <= 1'b0;
			o_br_valid <= 1'b0;
		end
		else begin
			o_wb_valid <= 1'b0;
			o_br_valid <= 1'b0;
			if (i_data.tag != tag) begin
				tag <= i_data.tag;
				o_wb_valid <= i_data.writes_rd;
				o_br_valid <= (i_data.branch_cond != BR_NONE);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_data.tag != tag) begin
			o_wb.rd <= i_data.rd;
			o_wb.value <= i_data.jump ? i_data.pc + 32'd4 : result;
			// jumps leave their target here too, next to the link writeback
			if (i_data.jump) begin
				o_br_taken <= 1'b1;
				o_br_target <= {result[31:1], 1'b0};
			end
			else if (i_data.branch_cond != BR_NONE) begin
				o_br_taken <= cond_true;
				o_br_target <= result;
			end
		end
	end

endmodule

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_inst_valid,
	input logic [31:0] i_inst,
	output logic o_wb_valid,
	output wb_data_t o_wb,
	output logic o_br_valid,
	output logic o_br_taken,
	output logic [31:0] o_br_target,
	output logic o_fault
);

	fetch_data_t fetch_data;
	decode_data_t decode_data;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [31:0] rs1_value;
	logic [31:0] rs2_value;

	rv_fetch #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_inst_valid(i_inst_valid),
		.i_inst(i_inst),
		.o_data(fetch_data)
	);

	rv_decode u_decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(fetch_data),
		.o_data(decode_data),
		.o_fault(o_fault)
	);

	// the writeback strobe doubles as the register file write port
	rv_regfile u_regfile (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rs1_value(rs1_value),
		.o_rs2_value(rs2_value),
		.i_we(o_wb_valid),
		.i_wb(o_wb)
	);

	rv_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(decode_data),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_rs1_value(rs1_value),
		.i_rs2_value(rs2_value),
		.o_wb_valid(o_wb_valid),
		.o_wb(o_wb),
		.o_br_valid(o_br_valid),
		.o_br_taken(o_br_taken),
		.o_br_target(o_br_target)
	);

endmodule

//--- rv_core_props.sv
`timescale 1ns/10ps

module rv_core_props (
	input logic i_clock,
	input logic i_reset,
	input logic i_wb_valid,
	input logic i_br_valid,
	input logic i_fault
);

	a_one_strobe: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_wb_valid && i_br_valid))
		else $error("writeback and branch strobes are high in the same cycle");

	a_reset_clears: assert property (@(posedge i_clock)
		i_reset |=> (!i_wb_valid && !i_br_valid && !i_fault))
		else $error("strobes or fault still high in the cycle after reset");

	// the fault flag may only drop through reset
	a_fault_sticky: assert property (@(posedge i_clock)
		(i_fault && !i_reset) |=> i_fault)
		else $error("o_fault fell without a reset");

endmodule

bind rv_core rv_core_props u_props (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_wb_valid(o_wb_valid),
	.i_br_valid(o_br_valid),
	.i_fault(o_fault)
);

//--- rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_inst_valid,
	input logic [31:0] i_inst,
	input logic [1:0] i_kind,
	input logic i_wb_valid,
	input wb_data_t i_wb,
	input logic i_br_valid,
	input logic i_br_taken,
	input logic [31:0] i_br_target,
	input logic i_fault
);

	localparam logic [1:0] KIND_WB = 2'd0;
	localparam logic [1:0] KIND_BR = 2'd1;
	localparam logic [1:0] KIND_JUMP = 2'd2;
	localparam logic [1:0] KIND_FAULT = 2'd3;
	localparam int NEVER = 32'h7fffffff;

	typedef struct packed {
		int idx;
		int due;
		logic [1:0] kind;
		logic [31:0] inst;
		logic [4:0] rd;
		logic [31:0] value;
		logic taken;
		logic [31:0] target;
	} expect_t;

	expect_t expect_q[$];
	logic [31:0] regs [32];
	logic [31:0] pc;
	int cycle = 0;
	int fault_from = NEVER;
	int test_idx = 0;
	int pending = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int error_count = 0;

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic reset_model();
		for (int i = 0; i < 32; i++)
			regs[i] = 32'h0;
		pc = RESET_PC;
		fault_from = NEVER;
		expect_q.delete();
	endtask

	// ####################################################################
	// reference model, one instruction per strobe
	// ####################################################################

	task automatic predict(input logic [31:0] inst, input logic [1:0] kind);
		expect_t e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		a = regs[inst[19:15]];
		b = regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		e = '0;
		e.idx = test_idx;
		e.due = cycle + 2; // fetch takes this edge and execute registers two edges later
		e.inst = inst;
		e.rd = inst[11:7];
		case (inst[6:0])
			7'b0110111: e.value = {inst[31:12], 12'h000};
			7'b0010111: e.value = pc + {inst[31:12], 12'h000};
			7'b0010011: e.value = alu_result(inst[14:12], inst[14:12] == 3'b101 && inst[30],
				a, imm_i);
			7'b0110011: e.value = alu_result(inst[14:12], inst[30], a, b);
			7'b1101111: begin
				e.kind = KIND_JUMP;
				e.value = pc + 32'd4;
				e.taken = 1'b1;
				e.target = pc + imm_j;
			end
			7'b1100111: begin
				e.kind = KIND_JUMP;
				e.value = pc + 32'd4;
				e.taken = 1'b1;
				e.target = (a + imm_i) & ~32'h1;
			end
			7'b1100011: begin
				e.kind = KIND_BR;
				e.taken = branch_taken(inst[14:12], a, b);
				e.target = pc + imm_b;
			end
			default: begin
				e.kind = KIND_FAULT;
				if (fault_from > cycle + 1)
					fault_from = cycle + 1; // decode flags it one edge after fetch
			end
		endcase
		if (e.kind != kind) begin
			$display("test %0d: table kind %0d does not match the model's kind %0d",
				test_idx, kind, e.kind);
			error_count++;
		end
		if ((e.kind == KIND_WB || e.kind == KIND_JUMP) && e.rd != 5'd0)
			regs[e.rd] = e.value;
		pc = pc + 32'd4;
		test_idx++;
		expect_q.push_back(e);
	endtask

	task automatic check_value(input int idx, input string name, input logic [31:0] got,
		input logic [31:0] exp, inout logic ok);
		if (got !== exp) begin
			$display("[ERROR] test %0d %s: got %h expected %h", idx, name, got, exp);
			error_count++;
			ok = 1'b0;
		end
	endtask

	task automatic check_event(input expect_t e);
		logic ok;
		ok = 1'b1;
		check_value(e.idx, "o_wb_valid", {31'b0, i_wb_valid},
			{31'b0, e.kind == KIND_WB || e.kind == KIND_JUMP}, ok);
		check_value(e.idx, "o_br_valid", {31'b0, i_br_valid}, {31'b0, e.kind == KIND_BR}, ok);
		if (e.kind == KIND_WB || e.kind == KIND_JUMP) begin
			check_value(e.idx, "o_wb.rd", {27'b0, i_wb.rd}, {27'b0, e.rd}, ok);
			check_value(e.idx, "o_wb.value", i_wb.value, e.value, ok);
		end
		if (e.kind == KIND_BR || e.kind == KIND_JUMP) begin
			check_value(e.idx, "o_br_taken", {31'b0, i_br_taken}, {31'b0, e.taken}, ok);
			check_value(e.idx, "o_br_target", i_br_target, e.target, ok);
		end
		if (e.kind == KIND_FAULT)
			check_value(e.idx, "o_fault", {31'b0, i_fault}, 32'h1, ok);
		$display("test %0d inst %h: %s", e.idx, e.inst, ok ? "ok" : "wrong");
		tests_run++;
		if (!ok)
			tests_failed++;
	endtask

	always @(posedge i_clock) begin
		cycle = cycle + 1;
		if (i_reset)
			reset_model();
		else if (i_inst_valid)
			predict(i_inst, i_kind);
		pending = expect_q.size();
	end

	// outputs settle after the rising edge, so they are compared on the falling one
	always @(negedge i_clock) begin
		if (i_fault !== (cycle >= fault_from)) begin
			$display("[ERROR] o_fault: got %h expected %h", i_fault, cycle >= fault_from);
			error_count++;
		end
		if (expect_q.size() > 0 && expect_q[0].due == cycle) begin
			check_event(expect_q.pop_front());
		end
		else if (i_wb_valid || i_br_valid) begin
			$display("a writeback or branch strobe came with no instruction due, cycle %0d",
				cycle);
			error_count++;
		end
		pending = expect_q.size();
	end

endmodule

//--- rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

	localparam logic [31:0] RESET_PC = 32'h0;
	localparam int MAX_ENTRIES = 64;
	localparam logic [1:0] KIND_WB = 2'd0;
	localparam logic [1:0] KIND_BR = 2'd1;
	localparam logic [1:0] KIND_JUMP = 2'd2;
	localparam logic [1:0] KIND_FAULT = 2'd3;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;

	logic clock;
	logic reset;
	logic inst_valid;
	logic [31:0] inst;
	logic [1:0] kind;
	logic wb_valid;
	wb_data_t wb;
	logic br_valid;
	logic br_taken;
	logic [31:0] br_target;
	logic fault;

	logic [31:0] table_inst [MAX_ENTRIES];
	logic table_gap [MAX_ENTRIES]; // entry is followed by an LFSR-drawn idle gap
	logic [1:0] table_kind [MAX_ENTRIES];
	int gaps [MAX_ENTRIES];
	int n_entries = 0;
	int cycles = 0;
	int cycle_limit = 1000;
	logic [31:0] lfsr = 32'h04993f26;

	rv_core #(
		.RESET_PC(RESET_PC)
	) u_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_inst_valid(inst_valid),
		.i_inst(inst),
		.o_wb_valid(wb_valid),
		.o_wb(wb),
		.o_br_valid(br_valid),
		.o_br_taken(br_taken),
		.o_br_target(br_target),
		.o_fault(fault)
	);

	rv_core_checker #(
		.RESET_PC(RESET_PC)
	) u_checker (
		.i_clock(clock),
		.i_reset(reset),
		.i_inst_valid(inst_valid),
		.i_inst(inst),
		.i_kind(kind),
		.i_wb_valid(wb_valid),
		.i_wb(wb),
		.i_br_valid(br_valid),
		.i_br_taken(br_taken),
		.i_br_target(br_target),
		.i_fault(fault)
	);

	// taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	task automatic add_entry(input logic [31:0] word, input logic gap, input logic [1:0] k);
		table_inst[n_entries] = word;
		table_gap[n_entries] = gap;
		table_kind[n_entries] = k;
		n_entries++;
	endtask

	// ####################################################################
	// stimulus table
	// ####################################################################

	task automatic build_table();
		add_entry(enc_u(20'h12345, 5'd1, OPC_LUI), 1'b0, KIND_WB);
		add_entry(enc_i(12'hfff, 5'd1, 3'b000, 5'd2, OPC_OP_IMM), 1'b0, KIND_WB);
		add_entry(enc_i(12'hff8, 5'd0, 3'b000, 5'd3, OPC_OP_IMM), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b0, KIND_WB); // add
		add_entry(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd5), 1'b0, KIND_WB); // sub
		add_entry(enc_r(7'h00, 5'd5, 5'd4, 3'b111, 5'd6), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd3, 5'd4, 3'b110, 5'd7), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd2, 5'd7, 3'b100, 5'd8), 1'b0, KIND_WB);
		add_entry(enc_i(12'h005, 5'd0, 3'b000, 5'd10, OPC_OP_IMM), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd10, 5'd2, 3'b001, 5'd9), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd10, 5'd3, 3'b101, 5'd11), 1'b0, KIND_WB);
		add_entry(enc_r(7'h20, 5'd10, 5'd3, 3'b101, 5'd12), 1'b0, KIND_WB);
		add_entry(enc_i(12'h003, 5'd1, 3'b001, 5'd13, OPC_OP_IMM), 1'b0, KIND_WB);
		add_entry(enc_i(12'h402, 5'd3, 3'b101, 5'd14, OPC_OP_IMM), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd1, 5'd3, 3'b010, 5'd15), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd1, 5'd3, 3'b011, 5'd16), 1'b0, KIND_WB);
		add_entry(enc_i(12'hff9, 5'd3, 3'b010, 5'd17, OPC_OP_IMM), 1'b1, KIND_WB);
		add_entry(enc_u(20'h00000, 5'd18, OPC_AUIPC), 1'b1, KIND_WB);
		add_entry(enc_u(20'hfffff, 5'd19, OPC_AUIPC), 1'b1, KIND_WB);
		add_entry(enc_u(20'h00000, 5'd20, OPC_AUIPC), 1'b1, KIND_WB);
		add_entry(enc_b(13'h0010, 5'd1, 5'd1, 3'b000), 1'b1, KIND_BR);
		add_entry(enc_b(13'h1ff8, 5'd2, 5'd1, 3'b000), 1'b0, KIND_BR);
		add_entry(enc_b(13'h1000, 5'd2, 5'd1, 3'b001), 1'b0, KIND_BR);
		add_entry(enc_b(13'h0008, 5'd2, 5'd2, 3'b001), 1'b0, KIND_BR);
		add_entry(enc_b(13'h000c, 5'd1, 5'd3, 3'b100), 1'b0, KIND_BR); // -8 < x1 signed
		add_entry(enc_b(13'h000c, 5'd3, 5'd1, 3'b100), 1'b0, KIND_BR);
		add_entry(enc_b(13'h1fe0, 5'd3, 5'd1, 3'b101), 1'b0, KIND_BR);
		add_entry(enc_b(13'h0004, 5'd1, 5'd3, 3'b101), 1'b0, KIND_BR);
		add_entry(enc_b(13'h0ffe, 5'd3, 5'd1, 3'b110), 1'b0, KIND_BR);
		add_entry(enc_b(13'h0014, 5'd1, 5'd3, 3'b110), 1'b0, KIND_BR);
		add_entry(enc_b(13'h0018, 5'd1, 5'd3, 3'b111), 1'b0, KIND_BR);
		add_entry(enc_b(13'h001c, 5'd3, 5'd1, 3'b111), 1'b0, KIND_BR);
		add_entry(enc_j(21'h000800, 5'd21), 1'b1, KIND_JUMP);
		add_entry(enc_j(21'h1fffec, 5'd0), 1'b0, KIND_JUMP); // link lands on x0
		add_entry(enc_r(7'h00, 5'd21, 5'd0, 3'b110, 5'd22), 1'b0, KIND_WB);
		add_entry(enc_i(12'hffd, 5'd1, 3'b000, 5'd23, OPC_JALR), 1'b1, KIND_JUMP);
		add_entry(enc_i(12'h000, 5'd1, 3'b010, 5'd25, OPC_LOAD), 1'b1, KIND_FAULT);
		add_entry(enc_i(12'd100, 5'd0, 3'b000, 5'd26, OPC_OP_IMM), 1'b0, KIND_WB);
		add_entry(enc_u(20'h00000, 5'd27, OPC_AUIPC), 1'b0, KIND_WB);
		add_entry(enc_r(7'h00, 5'd26, 5'd23, 3'b000, 5'd28), 1'b0, KIND_WB);
	endtask

	task automatic draw_gaps();
		logic [2:0] g;
		int total;
		total = 0;
		for (int i = 0; i < n_entries; i++) begin
			g = 3'b000;
			if (table_gap[i]) begin
				for (int b = 0; b < 3; b++) begin
					lfsr = lfsr_next(lfsr);
					g = {g[1:0], lfsr[0]};
				end
			end
			gaps[i] = int'(g);
			total += gaps[i];
		end
		cycle_limit = n_entries + total + 10;
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT did not deliver every result", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = 32'h0;
		kind = 2'd0;
		build_table();
		draw_gaps();
		repeat (2) @(posedge clock);
		#5;
		reset = 1'b0;

		for (int i = 0; i < n_entries; i++) begin
			inst_valid = 1'b1;
			inst = table_inst[i];
			kind = table_kind[i];
			@(posedge clock);
			#5;
			inst_valid = 1'b0;
			repeat (gaps[i]) begin
				@(posedge clock);
				#5;
			end
		end

		while (u_checker.pending != 0) begin
			@(posedge clock);
			#5;
		end

		// a final reset must clear the sticky fault
		reset = 1'b1;
		@(posedge clock);
		#5;
		reset = 1'b0;
		@(negedge clock);
		@(posedge clock);

		$display("tests run %0d, failed %0d, errors %0d", u_checker.tests_run,
			u_checker.tests_failed, u_checker.error_count);
		if (u_checker.error_count == 0 && u_checker.tests_run == n_entries) begin
			$display("TESTBENCH PASSED");
		end
		else begin
			if (u_checker.tests_run != n_entries)
				$display("only %0d of %0d instructions produced a result",
					u_checker.tests_run, n_entries);
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- rv_core.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
rv_core_props.sv
rv_core_checker.sv
rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the rv_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module rv_core_tb \
	-f rv_core.f -o rv_core_sim > build.log 2>&1; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status, see sim.log"
	exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0
